/* sim.f */
+incdir+sim
src/regfile_pkg.sv
src/ram_3r1w.sv
src/banked_regfile.sv
src/wb_arbiter.sv
src/read_forward.sv
src/regfile_top.sv
sim/tb_regfile_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the register file testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

TOP=tb_regfile_top
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps \
    --top-module "$TOP" -f sim.f

./obj_dir/"V$TOP" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "Simulation passed."
else
    echo "Simulation failed, see $LOG."
    exit 1
fi

/* sim/tb_tasks.svh */
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check_value(input reg_data_t actual, input reg_data_t expected,
                           input string name);
    if (actual !== expected) begin
        $display("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                 $time, name, actual, expected);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped at the first mismatch.");
    end
endtask

// Addresses change on the edge and data is sampled mid-cycle.
task automatic drive_reads(input reg_addr_t [NUM_RD-1:0] addrs);
    @(posedge clk);
    rd_addr <= addrs;
    @(negedge clk);
endtask

task automatic check_reads_model();
    for (int p = 0; p < NUM_RD; p++) begin
        check_value(rd_data[p], ref_rf[rd_addr[p]], $sformatf("rd_data_o[%0d]", p));
    end
endtask

task automatic check_reads_equal(input reg_data_t expected);
    for (int p = 0; p < NUM_RD; p++) begin
        check_value(rd_data[p], expected, $sformatf("rd_data_o[%0d]", p));
    end
endtask

task automatic write_port(input int port, input reg_addr_t addr, input reg_data_t data);
    @(posedge clk);
    wb_req[port] <= {1'b1, addr, data};
    @(negedge clk);
    while (!wb_ready[port]) begin
        @(negedge clk);
    end
    @(posedge clk); // Accepted here.
    wb_req[port] <= '0;
endtask

task automatic sweep_clears_all();
    // Requests on register 0 stay up through the sweep.
    wb_req[0] <= {1'b1, 5'd0, 32'hdead_beef};
    wb_req[1] <= {1'b1, 5'd0, 32'h1234_5678};
    for (int c = 0; c < 16; c++) begin
        @(negedge clk);
        check_value(32'(init_done), 32'd0, "init_done_o");
        check_value(32'(wb_ready), 32'd0, "wb_ready_o");
    end
    @(negedge clk);
    check_value(32'(init_done), 32'd1, "init_done_o");
    @(posedge clk);
    wb_req <= '0;
    for (int r = 0; r < 32; r++) begin
        drive_reads({5'(r + 24), 5'(r + 16), 5'(r + 8), 5'(r)});
        check_reads_equal('0);
    end
endtask

task automatic single_writes();
    reg_data_t              rnd;
    reg_addr_t [NUM_RD-1:0] addrs;
    for (int i = 0; i < N_SINGLE; i++) begin
        rnd = $random(seed);
        write_port(i % 2, rnd[4:0], $random(seed));
        for (int p = 0; p < NUM_RD; p++) begin
            rnd = $random(seed);
            addrs[p] = rnd[4:0];
        end
        drive_reads(addrs);
        check_reads_model();
    end
endtask

// One even and one odd register taken in one cycle.
task automatic dual_writes();
    reg_data_t rnd;
    reg_addr_t a0;
    reg_addr_t a1;
    reg_data_t d0;
    reg_data_t d1;
    for (int i = 0; i < N_DUAL; i++) begin
        rnd = $random(seed);
        a0 = {rnd[3:0] | 4'd1, 1'b0};
        a1 = {rnd[7:4], 1'b1};
        d0 = $random(seed);
        d1 = $random(seed);
        @(posedge clk);
        wb_req[0] <= {1'b1, a0, d0};
        wb_req[1] <= {1'b1, a1, d1};
        @(negedge clk);
        check_value(32'(wb_ready), 32'd3, "wb_ready_o");
        @(posedge clk);
        wb_req <= '0;
        drive_reads({a1, a0, a1, a0});
        check_value(rd_data[0], d0, "rd_data_o[0]");
        check_value(rd_data[1], d1, "rd_data_o[1]");
        check_reads_model();
    end
endtask

task automatic bank_conflicts();
    reg_data_t              rnd;
    reg_addr_t [NUM_WB-1:0] a;
    reg_data_t [NUM_WB-1:0] d;
    logic      [NUM_WB-1:0] pending;
    int                     last;
    for (int i = 0; i < N_CONFLICT; i++) begin
        rnd = $random(seed);
        a[0] = {rnd[3:0] | 4'd1, rnd[8]};
        a[1] = (i % 2 == 0) ? a[0] : {rnd[7:4], rnd[8]}; // Same register every other pass.
        d[0] = $random(seed);
        d[1] = $random(seed);
        last = 0;
        @(posedge clk);
        wb_req[0] <= {1'b1, a[0], d[0]};
        wb_req[1] <= {1'b1, a[1], d[1]};
        pending = 2'b11;
        @(negedge clk);
        check_value(32'($countones(wb_ready)), 32'd1, "wb_ready_o count");
        while (pending != '0) begin
            for (int w = 0; w < NUM_WB; w++) begin
                if (pending[w] && wb_ready[w]) begin
                    pending[w] = 1'b0;
                    last = w;
                end
            end
            @(posedge clk);
            for (int w = 0; w < NUM_WB; w++) begin
                if (!pending[w]) begin
                    wb_req[w].valid <= 1'b0;
                end
            end
            if (pending != '0) begin
                @(negedge clk);
            end
        end
        drive_reads({a[1], a[0], a[1], a[0]});
        if (a[0] == a[1]) begin
            check_value(rd_data[0], d[last], "rd_data_o[0]"); // Later grant wins.
        end
        check_reads_model();
    end
endtask

task automatic forwarding_and_r0();
    reg_data_t rnd;
    reg_addr_t a;
    reg_data_t d;
    for (int i = 0; i < N_FWD; i++) begin
        rnd = $random(seed);
        a = {rnd[3:0] | 4'd1, rnd[4]};
        d = $random(seed);
        @(posedge clk);
        wb_req[i % 2] <= {1'b1, a, d};
        rd_addr <= {a, a, a, a};
        @(negedge clk);
        check_value(32'(wb_ready[i % 2]), 32'd1, "wb_ready_o");
        check_reads_equal(d); // New data in the accept cycle.
        @(posedge clk);
        wb_req <= '0;
        @(negedge clk);
        check_reads_equal(d);
    end
    @(posedge clk);
    wb_req[0] <= {1'b1, 5'd0, 32'hffff_ffff};
    rd_addr <= '0;
    @(negedge clk);
    check_value(32'(wb_ready[0]), 32'd1, "wb_ready_o[0]");
    check_reads_equal('0);
    @(posedge clk);
    wb_req <= '0;
    @(negedge clk);
    check_reads_equal('0);
endtask

task automatic fair_alternation();
    reg_data_t rnd;
    reg_addr_t a0;
    reg_addr_t a1;
    int        prev;
    int        w;
    rnd = $random(seed);
    a0 = {rnd[3:0], 1'b1};
    a1 = {rnd[7:4] ^ 4'h8, 1'b1};
    prev = -1;
    @(posedge clk);
    wb_req[0] <= {1'b1, a0, 32'($random(seed))};
    wb_req[1] <= {1'b1, a1, 32'($random(seed))};
    for (int c = 0; c < N_FAIR; c++) begin
        @(negedge clk);
        check_value(32'($countones(wb_ready)), 32'd1, "wb_ready_o count");
        w = wb_ready[1] ? 1 : 0;
        if (prev >= 0) begin
            check_value(32'(w), 32'(1 - prev), "granted port");
        end
        prev = w;
        @(posedge clk);
        wb_req[w].data <= $random(seed); // Request stays up with new data.
    end
    wb_req <= '0;
    drive_reads({a1, a0, a1, a0});
    check_reads_model();
endtask

`endif

/* sim/tb_regfile_top.sv */
`timescale 1ns/1ps

module tb_regfile_top import regfile_pkg::*; ();

    localparam time CLK_PERIOD = 100;
    localparam int  N_SINGLE   = 40; // Writes, each with a read-back.
    localparam int  N_DUAL     = 8;
    localparam int  N_CONFLICT = 8;
    localparam int  N_FWD      = 6;
    localparam int  N_FAIR     = 8;  // Cycles with both ports held on one bank.

    // Operation count and cycle allowance, for the watchdog.
    localparam int  NUM_OPS    = 3 + 16 + 32 + 2 * N_SINGLE + N_DUAL + 2 * N_CONFLICT
                                 + 3 * N_FWD + N_FAIR + 8;
    localparam int  OP_CYCLES  = 4;

    logic                   clk;
    logic                   rst;
    wb_req_t   [NUM_WB-1:0] wb_req;
    logic      [NUM_WB-1:0] wb_ready;
    reg_addr_t [NUM_RD-1:0] rd_addr;
    reg_data_t [NUM_RD-1:0] rd_data;
    logic                   init_done;

    reg_data_t ref_rf [32] = '{default: '0}; // Reference register contents.
    integer    seed;

    regfile_top #(
        .RESET_NEED (1'b1)
    ) u_regfile_top (
        .clk         (clk),
        .rst         (rst),
        .wb_req_i    (wb_req),
        .wb_ready_o  (wb_ready),
        .rd_addr_i   (rd_addr),
        .rd_data_o   (rd_data),
        .init_done_o (init_done)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_tasks.svh"

    // Model takes every write accepted at the ports.
    always @(posedge clk) begin
        if (!rst) begin
            for (int w = 0; w < NUM_WB; w++) begin
                if (wb_req[w].valid && wb_ready[w] && (wb_req[w].addr != '0)) begin
                    ref_rf[wb_req[w].addr] = wb_req[w].data;
                end
            end
        end
    end

    // Never two writes into one bank.
    always @(negedge clk) begin
        if (!rst && wb_req[0].valid && wb_req[1].valid
            && (wb_req[0].addr[0] == wb_req[1].addr[0])) begin
            check_value(32'(&wb_ready), 32'd0, "wb_ready_o both high on one bank");
        end
    end

    initial begin
        #(CLK_PERIOD * NUM_OPS * OP_CYCLES);
        $display("Watchdog timeout: the tests did not finish in the allowed time.");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired.");
    end

    initial begin
        seed = 80;
        rst     <= 1'b1;
        wb_req  <= '0;
        rd_addr <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        sweep_clears_all();
        single_writes();
        dual_writes();
        bank_conflicts();
        forwarding_and_r0();
        fair_alternation();

        repeat (2) @(posedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* src/regfile_top.sv */
`timescale 1ns/1ps

module regfile_top import regfile_pkg::*; #(
    parameter bit RESET_NEED = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  wb_req_t   [NUM_WB-1:0] wb_req_i,
    output logic      [NUM_WB-1:0] wb_ready_o,
    input  reg_addr_t [NUM_RD-1:0] rd_addr_i,
    output reg_data_t [NUM_RD-1:0] rd_data_o,
    output logic                   init_done_o
);

    wb_req_t   [NUM_WB-1:0] wr_grant;   // Writes done this cycle.
    reg_data_t [NUM_RD-1:0] rf_rd_data; // Storage output, before bypass.
    logic                   init_done;

    assign init_done_o = init_done;

    wb_arbiter u_wb_arbiter (
        .clk         (clk),
        .rst         (rst),
        .req_i       (wb_req_i),
        .init_done_i (init_done),
        .ready_o     (wb_ready_o),
        .grant_o     (wr_grant)
    );

    banked_regfile #(
        .RESET_NEED (RESET_NEED)
    ) u_banked_regfile (
        .clk         (clk),
        .rst         (rst),
        .wr_i        (wr_grant),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rf_rd_data),
        .init_done_o (init_done)
    );

    read_forward u_read_forward (
        .rd_addr_i  (rd_addr_i),
        .raw_data_i (rf_rd_data),
        .grant_i    (wr_grant),
        .rd_data_o  (rd_data_o)
    );

endmodule

/* src/read_forward.sv */
`timescale 1ns/1ps

// Bypass of this cycle's writes onto the read ports.
module read_forward import regfile_pkg::*; (
    input  reg_addr_t [NUM_RD-1:0] rd_addr_i,
    input  reg_data_t [NUM_RD-1:0] raw_data_i,
    input  wb_req_t   [NUM_WB-1:0] grant_i,
    output reg_data_t [NUM_RD-1:0] rd_data_o
);

    logic [NUM_RD-1:0][NUM_WB-1:0] hit;

    // Address match against each live grant.
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            for (int w = 0; w < NUM_WB; w++) begin
                hit[p][w] = grant_i[w].valid && (grant_i[w].addr == rd_addr_i[p]);
            end
        end
    end

    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            rd_data_o[p] = raw_data_i[p];
            // Never two grants to one register.
            for (int w = 0; w < NUM_WB; w++) begin
                if (hit[p][w]) begin
                    rd_data_o[p] = grant_i[w].data;
                end
            end
            if (rd_addr_i[p] == '0) begin
                rd_data_o[p] = '0; // Hardwired zero.
            end
        end
    end

endmodule

/* src/wb_arbiter.sv */
`timescale 1ns/1ps

// Two-port write-back arbiter, one write per bank per cycle.
module wb_arbiter import regfile_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  wb_req_t [NUM_WB-1:0] req_i,
    input  logic                 init_done_i,
    output logic    [NUM_WB-1:0] ready_o,
    output wb_req_t [NUM_WB-1:0] grant_o
);

    logic prio_q;    // Set when port 1 is favoured.
    logic same_bank;
    logic conflict;
    logic hold0;
    logic hold1;

    assign same_bank = req_i[0].addr[0] == req_i[1].addr[0];

    // Both valid on one bank.
    assign conflict = req_i[0].valid && req_i[1].valid && same_bank;

    // The port that loses the conflict is held off.
    assign hold0 = conflict && prio_q;
    assign hold1 = conflict && !prio_q;

    assign ready_o[0] = init_done_i && !hold0;
    assign ready_o[1] = init_done_i && !hold1;

    // Flip priority after every resolved conflict.
    always_ff @(posedge clk) begin
        if (rst) begin
            prio_q <= 1'b0;
        end else if (conflict && init_done_i) begin
            prio_q <= ~prio_q;
        end
    end

    always_comb begin
        for (int w = 0; w < NUM_WB; w++) begin
            grant_o[w]      = req_i[w];
            grant_o[w].valid = req_i[w].valid && ready_o[w]
                              && (req_i[w].addr != '0); // Register 0 write dropped.
        end
    end

endmodule

/* src/banked_regfile.sv */
`timescale 1ns/1ps

module banked_regfile import regfile_pkg::*; #(
    parameter bit RESET_NEED = 1'b1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  wb_req_t   [NUM_WB-1:0] wr_i,
    input  reg_addr_t [NUM_RD-1:0] rd_addr_i,
    output reg_data_t [NUM_RD-1:0] rd_data_o,
    output logic                   init_done_o
);

    bank_row_t sweep_row_q;
    logic      init_done_q;
    bank_row_t rd_row  [NUM_RD];
    reg_data_t bank_rd [2][NUM_RD]; // Raw read data per bank.

    // Clearing sweep, one row of both banks per cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_row_q <= '0;
            init_done_q <= ~RESET_NEED;
        end else if (!init_done_q) begin
            sweep_row_q <= sweep_row_q + 4'd1;
            if (sweep_row_q == '1) begin
                init_done_q <= 1'b1; // Last row written.
            end
        end
    end

    assign init_done_o = init_done_q;

    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            rd_row[p] = rd_addr_i[p][4:1];
        end
    end

    // Bank 0 holds even registers, bank 1 odd ones.
    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic      gsel0;
        logic      gsel1;
        logic      bank_we;
        bank_row_t bank_waddr;
        reg_data_t bank_wdata;

        // At most one grant per bank, the arbiter sees to that.
        assign gsel0 = wr_i[0].valid && (wr_i[0].addr[0] == 1'(b));
        assign gsel1 = wr_i[1].valid && (wr_i[1].addr[0] == 1'(b));

        always_comb begin
            bank_we    = 1'b0;
            bank_waddr = sweep_row_q;
            bank_wdata = '0;
            if (!init_done_q) begin
                bank_we = 1'b1; // Sweep writes zero.
            end else if (gsel0) begin
                bank_we    = 1'b1;
                bank_waddr = wr_i[0].addr[4:1];
                bank_wdata = wr_i[0].data;
            end else if (gsel1) begin
                bank_we    = 1'b1;
                bank_waddr = wr_i[1].addr[4:1];
                bank_wdata = wr_i[1].data;
            end
        end

        // Reads 0 to 2.
        ram_3r1w u_ram_lo (
            .clk      (clk),
            .addr0_i  (rd_row[0]),
            .addr1_i  (rd_row[1]),
            .addr2_i  (rd_row[2]),
            .waddr_i  (bank_waddr),
            .wdata_i  (bank_wdata),
            .we_i     (bank_we),
            .rdata0_o (bank_rd[b][0]),
            .rdata1_o (bank_rd[b][1]),
            .rdata2_o (bank_rd[b][2])
        );

        // Read 3, a copy of the same contents.
        ram_3r1w u_ram_hi (
            .clk      (clk),
            .addr0_i  (rd_row[3]),
            .addr1_i  ('0),
            .addr2_i  ('0),
            .waddr_i  (bank_waddr),
            .wdata_i  (bank_wdata),
            .we_i     (bank_we),
            .rdata0_o (bank_rd[b][3]),
            .rdata1_o (),
            .rdata2_o ()
        );
    end

    // Bank select by address parity.
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            if (rd_addr_i[p][0]) begin
                rd_data_o[p] = bank_rd[1][p];
            end else begin
                rd_data_o[p] = bank_rd[0][p];
            end
        end
    end

endmodule

/* src/ram_3r1w.sv */
`timescale 1ns/1ps

// Distributed RAM model, one bank half.
module ram_3r1w import regfile_pkg::*; (
    input  logic      clk,
    input  bank_row_t addr0_i,
    input  bank_row_t addr1_i,
    input  bank_row_t addr2_i,
    input  bank_row_t waddr_i,
    input  reg_data_t wdata_i,
    input  logic      we_i,
    output reg_data_t rdata0_o,
    output reg_data_t rdata1_o,
    output reg_data_t rdata2_o
);

    localparam int DEPTH = 2 ** $bits(bank_row_t);

    reg_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Asynchronous reads.
    assign rdata0_o = mem[addr0_i];
    assign rdata1_o = mem[addr1_i];
    assign rdata2_o = mem[addr2_i];

endmodule

/* src/regfile_pkg.sv */
package regfile_pkg;

    // Register index, 32 architectural registers.
    typedef logic [4:0] reg_addr_t;

    // Register value.
    typedef logic [31:0] reg_data_t;

    // Row inside one bank, taken from address bits 4 to 1.
    typedef logic [3:0] bank_row_t;

    // Write-back request as seen by the pipeline and the storage.
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } wb_req_t;

    localparam int NUM_RD = 4; // Read ports.
    localparam int NUM_WB = 2; // Write-back ports.

endpackage
